// File: verilog/nora_pkg.sv
/* NORA bus glue shared definitions
 * address map, register offsets, CPU phase timing, button and LED timing,
 * and the packed bus structs passed between the blocks
 */
package nora_pkg;

    // CPU clock phasing, clk6x cycles per CPU cycle
    localparam int CPU_PHASES = 6;
    typedef logic [$clog2(CPU_PHASES)-1:0] phase_t;

    localparam phase_t PH_SETUP      = 2;      // latch address, set up selects
    localparam phase_t PH_RELEASE_WR = 4;      // write strobe
    localparam phase_t PH_RELEASE_CS = 5;      // end of cycle

    // address map
    localparam logic [7:0]  IO_PAGE     = 8'h9F;
    localparam logic [7:0]  VIA1_BASE   = 8'h00;   // 16-byte window in io page
    localparam logic [7:0]  SCRB_BASE   = 8'h50;
    localparam logic [15:0] BANK_WIN_LO = 16'hA000;
    localparam logic [15:0] BANK_WIN_HI = 16'hBFFF;
    localparam logic [7:0]  IDLE_DATA   = 8'hFF;   // unmapped reads

    // system register offsets
    localparam logic [3:0] SCRB_RAMBANK  = 4'd0;
    localparam logic [3:0] SCRB_BANKMASK = 4'd1;
    localparam logic [7:0] BANKMASK_RESET = 8'h7F; // 128 banks after reset

    // via register offsets, 65C22 order
    localparam logic [3:0] VIA_ORB  = 4'd0;
    localparam logic [3:0] VIA_ORA  = 4'd1;
    localparam logic [3:0] VIA_DDRB = 4'd2;
    localparam logic [3:0] VIA_DDRA = 4'd3;

    // attention button
    localparam int DEBOUNCE_CYCLES  = 16;
    localparam int NMI_PULSE_CYCLES = 12;
    typedef logic [$clog2(DEBOUNCE_CYCLES)-1:0]    deb_cnt_t;
    typedef logic [$clog2(NMI_PULSE_CYCLES+1)-1:0] pulse_cnt_t;

    // led blinker divider
    localparam int BLINK_DIV_BITS = 6;

    // cpu side of a bus cycle
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        rwn;      // 1 = read
    } cpu_bus_t;

    // shared internal slave bus
    typedef struct packed {
        logic [3:0] offs;      // register offset in slave window
        logic [7:0] wdata;
        logic       rwn;
        logic       wstb;      // single-cycle write strobe
    } slv_bus_t;

    // one gpio port towards the pins
    typedef struct packed {
        logic [7:0] value;
        logic [7:0] oe;        // 1 = drive
    } gpio_port_t;

endpackage

// File: verilog/cpu_phaser.sv
/* CPU clock phaser
 * free-running six-phase counter making the CPU clock and the
 * setup, write-release and cycle-end strobes of each bus cycle
 */
`timescale 1ns/1ps

module cpu_phaser (
    input  logic clk6x,
    input  logic reset_i,
    output logic cphi2_o,       // cpu clock, high in upper half
    output logic setup_cs_o,    // phase 2 pulse
    output logic release_wr_o,  // phase 4 pulse
    output logic release_cs_o   // phase 5 pulse
);

    nora_pkg::phase_t phase_q;  // 0 .. CPU_PHASES-1

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
        begin
            phase_q <= '0;
        end
        else if (phase_q == nora_pkg::phase_t'(nora_pkg::CPU_PHASES - 1))
        begin
            phase_q <= '0;      // cphi2 falls here, new cycle
        end
        else
        begin
            phase_q <= phase_q + 1'b1;
        end
    end

    // decoded straight from the counter, all low in phase 0
    assign cphi2_o      = (phase_q > nora_pkg::PH_SETUP);
    assign setup_cs_o   = (phase_q == nora_pkg::PH_SETUP);
    assign release_wr_o = (phase_q == nora_pkg::PH_RELEASE_WR);
    assign release_cs_o = (phase_q == nora_pkg::PH_RELEASE_CS);

endmodule

// File: verilog/bus_decoder.sv
/* CPU bus decoder
 * latches the CPU address at setup, selects the internal slave,
 * forms the write strobe and muxes read data back to the CPU
 */
`timescale 1ns/1ps

module bus_decoder (
    input  logic               clk6x,
    input  logic               reset_i,
    input  nora_pkg::cpu_bus_t cpu_i,
    input  logic               setup_cs_i,
    input  logic               release_wr_i,
    input  logic               cphi2_i,
    input  logic [7:0]         via_rdata_i,
    input  logic [7:0]         scrb_rdata_i,
    output nora_pkg::slv_bus_t slv_o,
    output logic               via_sel_o,
    output logic               scrb_sel_o,
    output logic [15:0]        addr_o,
    output logic [7:0]         cpu_data_o,
    output logic               cpu_data_oe_o
);

    logic [15:0] addr_q;        // latched cpu address
    logic        rwn_q;
    logic        io_page;

    // address and direction are stable by phase 2
    always_ff @(posedge clk6x)
    begin
        if (reset_i)
        begin
            addr_q <= '0;
            rwn_q  <= 1'b1;     // idle as read
        end
        else if (setup_cs_i)
        begin
            addr_q <= cpu_i.addr;
            rwn_q  <= cpu_i.rwn;
        end
    end

    assign io_page    = (addr_q[15:8] == nora_pkg::IO_PAGE);
    // 16-byte windows, low nibble is the register offset
    assign via_sel_o  = io_page && ((addr_q[7:0] & 8'hF0) == nora_pkg::VIA1_BASE);
    assign scrb_sel_o = io_page && ((addr_q[7:0] & 8'hF0) == nora_pkg::SCRB_BASE);

    assign addr_o = addr_q;

    // write data only valid from phase 4, taken live from the cpu side
    assign slv_o.offs  = addr_q[3:0];
    assign slv_o.wdata = cpu_i.wdata;
    assign slv_o.rwn   = rwn_q;
    assign slv_o.wstb  = release_wr_i && !rwn_q && (via_sel_o || scrb_sel_o);

    always_comb
    begin
        if (via_sel_o)
        begin
            cpu_data_o = via_rdata_i;
        end
        else if (scrb_sel_o)
        begin
            cpu_data_o = scrb_rdata_i;
        end
        else
        begin
            cpu_data_o = nora_pkg::IDLE_DATA;   // nothing mapped
        end
    end

    // drive the cpu data bus in the phi2-high half of reads only
    assign cpu_data_oe_o = cphi2_i && rwn_q;

endmodule

// File: verilog/sys_regs.sv
/* System control registers
 * RAM bank register and bank mask, and the masked bank
 * on the high memory address bits inside the banked window
 */
`timescale 1ns/1ps

module sys_regs (
    input  logic               clk6x,
    input  logic               reset_i,
    input  nora_pkg::slv_bus_t slv_i,
    input  logic               sel_i,
    input  logic [15:0]        addr_i,      // latched cpu address
    output logic [7:0]         rdata_o,
    output logic [7:0]         mem_bank_o
);

    logic [7:0] rambank_q;
    logic [7:0] bankmask_q;
    logic       in_window;

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
        begin
            rambank_q  <= '0;
            bankmask_q <= nora_pkg::BANKMASK_RESET;
        end
        else if (sel_i && slv_i.wstb)
        begin
            if (slv_i.offs == nora_pkg::SCRB_RAMBANK)
            begin
                rambank_q <= slv_i.wdata;
            end
            if (slv_i.offs == nora_pkg::SCRB_BANKMASK)
            begin
                bankmask_q <= slv_i.wdata;
            end
        end
    end

    always_comb
    begin
        case (slv_i.offs)
            nora_pkg::SCRB_RAMBANK:  rdata_o = rambank_q;    // unmasked
            nora_pkg::SCRB_BANKMASK: rdata_o = bankmask_q;
            default:                 rdata_o = nora_pkg::IDLE_DATA;
        endcase
    end

    assign in_window = (addr_i >= nora_pkg::BANK_WIN_LO) && (addr_i <= nora_pkg::BANK_WIN_HI);

    // zero outside the window, i.e. bank 0
    assign mem_bank_o = in_window ? (rambank_q & bankmask_q) : 8'h00;

endmodule

// File: verilog/simple_via.sv
/* Simplified VIA
 * two 8-bit GPIO ports with data direction registers,
 * register layout as in the 65C22
 */
`timescale 1ns/1ps

module simple_via (
    input  logic                 clk6x,
    input  logic                 reset_i,
    input  nora_pkg::slv_bus_t   slv_i,
    input  logic                 sel_i,
    input  logic [7:0]           port_a_i,
    input  logic [7:0]           port_b_i,
    output nora_pkg::gpio_port_t port_a_o,
    output nora_pkg::gpio_port_t port_b_o,
    output logic [7:0]           rdata_o
);

    logic [7:0] ora_q;
    logic [7:0] orb_q;
    logic [7:0] ddra_q;     // 1 = output
    logic [7:0] ddrb_q;
    logic       wr_en;

    // per bit: output reg where driven, pin where input
    function automatic logic [7:0] port_read(input logic [7:0] outreg,
                                             input logic [7:0] ddr,
                                             input logic [7:0] pins);
        return (outreg & ddr) | (pins & ~ddr);
    endfunction

    assign wr_en = sel_i && slv_i.wstb;

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
        begin
            ora_q  <= '0;
            orb_q  <= '0;
            ddra_q <= '0;   // all inputs after reset
            ddrb_q <= '0;
        end
        else if (wr_en)
        begin
            case (slv_i.offs)
                nora_pkg::VIA_ORB:  orb_q  <= slv_i.wdata;
                nora_pkg::VIA_ORA:  ora_q  <= slv_i.wdata;
                nora_pkg::VIA_DDRB: ddrb_q <= slv_i.wdata;
                nora_pkg::VIA_DDRA: ddra_q <= slv_i.wdata;
                default:
                begin
                    // timers etc. not implemented, write ignored
                end
            endcase
        end
    end

    always_comb
    begin
        case (slv_i.offs)
            nora_pkg::VIA_ORB:  rdata_o = port_read(orb_q, ddrb_q, port_b_i);
            nora_pkg::VIA_ORA:  rdata_o = port_read(ora_q, ddra_q, port_a_i);
            nora_pkg::VIA_DDRB: rdata_o = ddrb_q;
            nora_pkg::VIA_DDRA: rdata_o = ddra_q;
            default:            rdata_o = nora_pkg::IDLE_DATA;
        endcase
    end

    // pin side
    assign port_a_o.value = ora_q;
    assign port_a_o.oe    = ddra_q;
    assign port_b_o.value = orb_q;
    assign port_b_o.oe    = ddrb_q;

endmodule

// File: verilog/atten_button.sv
/* Attention button
 * synchronizes and debounces the active-low button and fires
 * one fixed-length NMI pulse per accepted press
 */
`timescale 1ns/1ps

module atten_button (
    input  logic clk6x,
    input  logic reset_i,
    input  logic attbtn_i,      // active low, async
    output logic cpu_nmin_o     // active low
);

    logic                 btn_s1;
    logic                 btn_s2;      // synchronized, low = pressed
    logic                 armed_q;     // released since last pulse
    nora_pkg::deb_cnt_t   deb_q;
    nora_pkg::pulse_cnt_t pulse_q;
    logic                 accept;
    logic                 nmin_q;

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
        begin
            btn_s1 <= 1'b1;
            btn_s2 <= 1'b1;
        end
        else
        begin
            btn_s1 <= attbtn_i;
            btn_s2 <= btn_s1;
        end
    end

    // press held long enough, and not yet reported
    assign accept = !btn_s2 && armed_q
                    && (deb_q == nora_pkg::deb_cnt_t'(nora_pkg::DEBOUNCE_CYCLES - 1));

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
        begin
            deb_q   <= '0;
            armed_q <= 1'b0;
        end
        else if (btn_s2)
        begin
            deb_q   <= '0;      // released, glitch ends here too
            armed_q <= 1'b1;
        end
        else if (accept)
        begin
            deb_q   <= '0;
            armed_q <= 1'b0;    // wait for release
        end
        else if (armed_q)
        begin
            deb_q <= deb_q + 1'b1;
        end
    end

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
        begin
            pulse_q <= '0;
            nmin_q  <= 1'b1;
        end
        else
        begin
            if (accept)
                pulse_q <= nora_pkg::pulse_cnt_t'(nora_pkg::NMI_PULSE_CYCLES);
            else if (pulse_q != '0)
                pulse_q <= pulse_q - 1'b1;
            nmin_q <= (pulse_q == '0);  // low while counting
        end
    end

    assign cpu_nmin_o = nmin_q;

endmodule

// File: verilog/led_blinker.sv
/* LED blinker
 * free-running divider, toggles the LED level on every wrap
 */
`timescale 1ns/1ps

module led_blinker (
    input  logic clk6x,
    input  logic reset_i,
    output logic led_o
);

    logic [nora_pkg::BLINK_DIV_BITS-1:0] div_q;
    logic                                led_q;

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
        begin
            div_q <= '0;
            led_q <= 1'b0;
        end
        else
        begin
            div_q <= div_q + 1'b1;
            if (&div_q)
                led_q <= ~led_q;    // wrap
        end
    end

    assign led_o = led_q;

endmodule

// File: verilog/nora_core.sv
/* NORA core top
 * CPU phaser, bus decoder, system registers, VIA, attention
 * button and LED blinker on one clk6x domain
 */
`timescale 1ns/1ps

module nora_core (
    input  logic                 clk6x,
    input  logic                 reset_i,
    input  nora_pkg::cpu_bus_t   cpu_i,
    input  logic                 attbtn_i,
    input  logic [7:0]           port_a_i,
    input  logic [7:0]           port_b_i,
    output logic                 cphi2_o,
    output logic [7:0]           cpu_data_o,
    output logic                 cpu_data_oe_o,
    output logic                 cpu_nmin_o,
    output logic [7:0]           mem_bank_o,
    output nora_pkg::gpio_port_t port_a_o,
    output nora_pkg::gpio_port_t port_b_o,
    output logic                 led_o
);

    logic               setup_cs;
    logic               release_wr;
    nora_pkg::slv_bus_t slv;
    logic               via_sel;
    logic               scrb_sel;
    logic [15:0]        cpu_addr;       // latched at setup
    logic [7:0]         via_rdata;
    logic [7:0]         scrb_rdata;
    logic               blink_led;

    cpu_phaser u_phaser (
        .clk6x        (clk6x),
        .reset_i      (reset_i),
        .cphi2_o      (cphi2_o),
        .setup_cs_o   (setup_cs),
        .release_wr_o (release_wr),
        .release_cs_o ()
    );

    bus_decoder u_decoder (
        .clk6x         (clk6x),
        .reset_i       (reset_i),
        .cpu_i         (cpu_i),
        .setup_cs_i    (setup_cs),
        .release_wr_i  (release_wr),
        .cphi2_i       (cphi2_o),
        .via_rdata_i   (via_rdata),
        .scrb_rdata_i  (scrb_rdata),
        .slv_o         (slv),
        .via_sel_o     (via_sel),
        .scrb_sel_o    (scrb_sel),
        .addr_o        (cpu_addr),
        .cpu_data_o    (cpu_data_o),
        .cpu_data_oe_o (cpu_data_oe_o)
    );

    sys_regs u_scrb (
        .clk6x      (clk6x),
        .reset_i    (reset_i),
        .slv_i      (slv),
        .sel_i      (scrb_sel),
        .addr_i     (cpu_addr),
        .rdata_o    (scrb_rdata),
        .mem_bank_o (mem_bank_o)
    );

    simple_via u_via1 (
        .clk6x    (clk6x),
        .reset_i  (reset_i),
        .slv_i    (slv),
        .sel_i    (via_sel),
        .port_a_i (port_a_i),
        .port_b_i (port_b_i),
        .port_a_o (port_a_o),
        .port_b_o (port_b_o),
        .rdata_o  (via_rdata)
    );

    atten_button u_abtn (
        .clk6x      (clk6x),
        .reset_i    (reset_i),
        .attbtn_i   (attbtn_i),
        .cpu_nmin_o (cpu_nmin_o)
    );

    led_blinker u_blink (
        .clk6x   (clk6x),
        .reset_i (reset_i),
        .led_o   (blink_led)
    );

    // portb bit 0 takes over the led once made an output
    assign led_o = port_b_o.oe[0] ? port_b_o.value[0] : blink_led;

endmodule

// File: dv/nora_core_tb.sv
/* NORA core testbench
 * table-driven CPU bus cycles against the decoder, system registers
 * and VIA, then LED source selection and attention button timing
 */
`timescale 1ns/1ps

module nora_core_tb;

    typedef struct packed {
        logic [15:0] addr;
        logic        rwn;          // 1 = read
        logic [7:0]  wdata;
        logic [7:0]  exp_data;     // ignored on writes
        logic [7:0]  exp_bank;     // mem_bank_o during the cycle
    } row_t;

    localparam int TABLE_ROWS   = 32;      // upper bound on rows queued
    localparam int BLINK_ALLOW  = 3 * 2 * (1 << nora_pkg::BLINK_DIV_BITS);
    localparam int BUTTON_ALLOW = 128;
    localparam int TIMEOUT_CYCLES =
        (8 + TABLE_ROWS * (nora_pkg::CPU_PHASES + 1) + BLINK_ALLOW + BUTTON_ALLOW) * 2;

    logic                 clk6x;
    logic                 reset_i;
    nora_pkg::cpu_bus_t   cpu_i;
    logic                 attbtn_i;
    logic [7:0]           port_a_i;
    logic [7:0]           port_b_i;
    logic                 cphi2_o;
    logic [7:0]           cpu_data_o;
    logic                 cpu_data_oe_o;
    logic                 cpu_nmin_o;
    logic [7:0]           mem_bank_o;
    nora_pkg::gpio_port_t port_a_o;
    nora_pkg::gpio_port_t port_b_o;
    logic                 led_o;

    row_t rows[$];          // pending stimulus rows
    int   errors;
    int   tests_run;
    int   tests_failed;
    int   cycles;

    nora_core uut (.*);

    initial
    begin
        clk6x = 1'b0;
        forever #10 clk6x = ~clk6x;     // 20 ns
    end

    // hard stop if the cpu side never completes
    initial
    begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk6x);
            cycles++;
        end
        $display("run stopped by timeout after %0d clock cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp)
        begin
            $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic add_row(input logic [15:0] addr, input logic rwn, input logic [7:0] wdata,
                           input logic [7:0] exp_data, input logic [7:0] exp_bank);
        rows.push_back({addr, rwn, wdata, exp_data, exp_bank});
    endtask

    // cpu clock low in phases 0 to 2, high in 3 to 5
    task automatic phi2_shape();
        int ph;
        @(negedge cphi2_o);                 // phase 0
        for (ph = 0; ph < nora_pkg::CPU_PHASES; ph++)
        begin
            @(negedge clk6x);
            check("cphi2_o", 16'(cphi2_o), 16'(ph >= 3));
        end
    endtask

    // one cpu cycle, sampled mid phase 3 with cphi2 high
    task automatic bus_cycle(input row_t r);
        @(negedge cphi2_o);                 // phase 0
        @(posedge clk6x);
        cpu_i <= {r.addr, r.wdata, r.rwn};  // stable well before setup
        @(negedge clk6x);
        check("cpu_data_oe_o", 16'(cpu_data_oe_o), 16'h0000);  // phi2 low half
        @(posedge cphi2_o);
        @(negedge clk6x);
        check("cpu_data_oe_o", 16'(cpu_data_oe_o), 16'(r.rwn));
        if (r.rwn)
            check("cpu_data_o", 16'(cpu_data_o), 16'(r.exp_data));
        check("mem_bank_o", 16'(mem_bank_o), 16'(r.exp_bank));
    endtask

    task automatic apply_rows();
        row_t r;
        while (rows.size() > 0)
        begin
            r = rows.pop_front();
            bus_cycle(r);
        end
        // last write lands at phase 4, then park on an idle read
        @(negedge cphi2_o);
        @(posedge clk6x);
        cpu_i <= {16'h0000, 8'h00, 1'b1};
    endtask

    task automatic led_steady(input logic level, input int n);
        repeat (n)
        begin
            @(negedge clk6x);
            if (led_o !== level)
            begin
                check("led_o", 16'(led_o), 16'(level));
                return;     // one report is enough
            end
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before)
        begin
            $display("test %0d %s: passed", tests_run, name);
        end
        else
        begin
            tests_failed++;
            $display("test %0d %s: FAILED with %0d errors", tests_run, name,
                     errors - errors_before);
        end
    endtask

    initial
    begin
        int          start;
        int          waited;
        int          fall_at;
        int          low_len;
        int          k;
        logic [15:0] a;
        logic [7:0]  pa;
        logic        led_prev;

        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(83225));
        pa = 8'($urandom);
        if (pa[7:4] == 4'hA)
            pa[7:4] = 4'h5;                 // pins unlike ORA in both nibbles
        if (pa[3:0] == 4'h5)
            pa[3:0] = 4'hA;
        reset_i  = 1'b1;
        cpu_i    = {16'h0000, 8'h00, 1'b1};
        attbtn_i = 1'b1;                    // released
        port_a_i = 8'h00;
        port_b_i = 8'h00;
        repeat (8) @(posedge clk6x);
        reset_i  <= 1'b0;
        port_a_i <= pa;

        // unmapped space, incl. an empty io window and random addresses
        start = errors;
        phi2_shape();
        add_row(16'h0000, 1'b1, 8'h00, nora_pkg::IDLE_DATA, 8'h00);
        add_row(16'h9F20, 1'b1, 8'h00, nora_pkg::IDLE_DATA, 8'h00);
        repeat (4)
        begin
            a = 16'($urandom);
            if (a[15:8] == nora_pkg::IO_PAGE
                || (a >= nora_pkg::BANK_WIN_LO && a <= nora_pkg::BANK_WIN_HI))
                a[15] = ~a[15];             // moves out of io page and window
            add_row(a, 1'b1, 8'h00, nora_pkg::IDLE_DATA, 8'h00);
        end
        add_row(16'h1234, 1'b0, 8'h55, 8'h00, 8'h00);  // oe stays low
        apply_rows();
        end_test("unmapped reads", start);

        // bank register, mask and banked window
        start = errors;
        add_row(16'h9F51, 1'b1, 8'h00, 8'h7F, 8'h00);  // reset mask
        add_row(16'h9F50, 1'b0, 8'hC5, 8'h00, 8'h00);
        add_row(16'h9F50, 1'b1, 8'h00, 8'hC5, 8'h00);  // unmasked readback
        add_row(16'hA000, 1'b1, 8'h00, 8'hFF, 8'h45);  // C5 & 7F
        add_row(16'hBFFF, 1'b1, 8'h00, 8'hFF, 8'h45);
        add_row(16'hC000, 1'b1, 8'h00, 8'hFF, 8'h00);  // just past window
        add_row(16'h9F51, 1'b0, 8'hFF, 8'h00, 8'h00);
        add_row(16'h9F51, 1'b1, 8'h00, 8'hFF, 8'h00);
        add_row(16'hA800, 1'b1, 8'h00, 8'hFF, 8'hC5);
        add_row(16'h9F5F, 1'b1, 8'h00, 8'hFF, 8'h00);  // unused offset
        apply_rows();
        end_test("system registers", start);

        // port a, high nibble driven, low nibble from the pins
        start = errors;
        add_row(16'h9F03, 1'b0, 8'hF0, 8'h00, 8'h00);
        add_row(16'h9F01, 1'b0, 8'hA5, 8'h00, 8'h00);
        add_row(16'h9F03, 1'b1, 8'h00, 8'hF0, 8'h00);
        add_row(16'h9F01, 1'b1, 8'h00, 8'hA0 | (pa & 8'h0F), 8'h00);
        add_row(16'h9F04, 1'b1, 8'h00, 8'hFF, 8'h00);
        apply_rows();
        check("port_a_o.value", 16'(port_a_o.value), 16'h00A5);
        check("port_a_o.oe", 16'(port_a_o.oe), 16'h00F0);
        end_test("via gpio", start);

        // blinker owns the led until portb bit 0 is an output
        start = errors;
        @(negedge clk6x);
        led_prev = led_o;
        waited   = 0;
        while (led_o === led_prev && waited < 2 * (1 << nora_pkg::BLINK_DIV_BITS))
        begin
            @(negedge clk6x);
            waited++;
        end
        if (led_o === led_prev)
        begin
            $display("led_o did not toggle within %0d cycles with DDRB bit 0 clear", waited);
            errors++;
        end
        add_row(16'h9F02, 1'b0, 8'h01, 8'h00, 8'h00);
        add_row(16'h9F00, 1'b0, 8'h01, 8'h00, 8'h00);
        add_row(16'h9F02, 1'b1, 8'h00, 8'h01, 8'h00);  // ddrb readback
        apply_rows();
        check("port_b_o", 16'(port_b_o), 16'h0101);    // value, oe
        led_steady(1'b1, 2 * (1 << nora_pkg::BLINK_DIV_BITS));
        add_row(16'h9F00, 1'b0, 8'h00, 8'h00, 8'h00);
        apply_rows();
        check("port_b_o", 16'(port_b_o), 16'h0001);
        led_steady(1'b0, 2 * (1 << nora_pkg::BLINK_DIV_BITS));
        end_test("led source", start);

        // 40-cycle press, k counts edges after the press edge
        start   = errors;
        fall_at = 0;
        low_len = 0;
        @(posedge clk6x);
        attbtn_i <= 1'b0;
        for (k = 1; k <= 60; k++)
        begin
            @(posedge clk6x);
            if (k == 40)
                attbtn_i <= 1'b1;
            @(negedge clk6x);
            if (!cpu_nmin_o)
            begin
                if (fall_at == 0)
                    fall_at = k;
                low_len++;
            end
        end
        check("nmi fall cycle", 16'(fall_at), 16'(nora_pkg::DEBOUNCE_CYCLES + 3));
        check("nmi low cycles", 16'(low_len), 16'(nora_pkg::NMI_PULSE_CYCLES));
        @(posedge clk6x);
        attbtn_i <= 1'b0;                   // short glitch
        repeat (5) @(posedge clk6x);
        attbtn_i <= 1'b1;
        low_len = 0;
        repeat (40)
        begin
            @(negedge clk6x);
            if (!cpu_nmin_o)
                low_len++;
        end
        if (low_len != 0)
        begin
            $display("cpu_nmin_o went low after a 5-cycle button glitch");
            errors++;
        end
        end_test("attention button", start);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: nora_core.f
verilog/nora_pkg.sv
verilog/cpu_phaser.sv
verilog/bus_decoder.sv
verilog/sys_regs.sv
verilog/simple_via.sv
verilog/atten_button.sv
verilog/led_blinker.sv
verilog/nora_core.sv
dv/nora_core_tb.sv

// File: Makefile
SIM      := verilator
TOP      := nora_core_tb
FILELIST := nora_core.f
FLAGS    := --binary --timing -j 0 --top-module $(TOP)
OBJ_DIR  := obj_dir
LOG      := sim.log

SRCS     := $(shell grep -v '^+' $(FILELIST))
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "Simulation completed successfully" $(LOG) || (echo "pass line not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
